//--- fetch_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared types and constants for the instruction fetch front end and its
// memory bus. Modules refer to these by scoped names.
////////////////////////////////////////////////////////////////////////////

package fetch_pkg;

  localparam int ADDR_BITS        = 64;
  localparam int LINE_OFFSET_BITS = 3;   // 8-byte lines
  localparam int ICACHE_IDX_BITS  = 7;   // 128 lines by default

  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [31:0]          inst_t;
  typedef logic [63:0]          line_t;

  // Zero tag means refused on a response, no reply on a return
  typedef logic [3:0] mem_tag_t;

  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_cmd_e;

  // Request to the single memory bus
  typedef struct packed {
    bus_cmd_e command;
    addr_t    addr;
    line_t    data;   // Store data, ignored on loads
  } mem_req_t;

  // IF/ID packet handed to decode
  typedef struct packed {
    addr_t npc;
    inst_t ir;
    logic  valid;
  } fetch_pkt_t;

  // Alpha style no-op for empty pipeline slots
  localparam inst_t NOOP_INST = 32'h47ff_041f;

endpackage

//--- icache_mem.sv
////////////////////////////////////////////////////////////////////////////
// Instruction cache arrays, direct mapped with one 64-bit line per set.
// Lookup is combinational, fills land on the clock edge.
////////////////////////////////////////////////////////////////////////////

module icache_mem #(
  parameter  int ICACHE_IDX_BITS = fetch_pkg::ICACHE_IDX_BITS,
  localparam int TAG_BITS        = fetch_pkg::ADDR_BITS - fetch_pkg::LINE_OFFSET_BITS
                                   - ICACHE_IDX_BITS
) (
  input  logic                       clock,
  input  logic                       rst_n,

  // Fill port
  input  logic                       wr_en,
  input  logic [ICACHE_IDX_BITS-1:0] wr_idx,
  input  logic [TAG_BITS-1:0]        wr_tag,
  input  fetch_pkg::line_t           wr_data,

  // Lookup port
  input  logic [ICACHE_IDX_BITS-1:0] rd_idx,
  input  logic [TAG_BITS-1:0]        rd_tag,
  output fetch_pkg::line_t           rd_data,
  output logic                       rd_valid
);

  localparam int LINES = 1 << ICACHE_IDX_BITS;

  fetch_pkg::line_t    data_mem [LINES];
  logic [TAG_BITS-1:0] tag_mem  [LINES];
  logic [LINES-1:0]    valid_q;

  assign rd_data  = data_mem[rd_idx];
  assign rd_valid = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);

  // Valid bits clear on reset and set on a fill
  always_ff @(posedge clock)
  begin
    if (!rst_n)
      valid_q <= '0;
    else if (wr_en)
      valid_q[wr_idx] <= 1'b1;
  end

  always_ff @(posedge clock)
  begin
    if (wr_en)
    begin
      data_mem[wr_idx] <= wr_data;
      tag_mem[wr_idx]  <= wr_tag;
    end
  end

  // Controller must hand over a resolved tag with every fill
  a_fill_tag_known: assert property (@(posedge clock) disable iff (!rst_n)
    wr_en |-> !$isunknown(wr_tag));

endmodule

//--- fetch_bus_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Instruction cache controller. Looks up the fetch address, requests the
// line from memory on a miss and fills it when the tagged reply returns.
// Shares the memory bus with the data port, which always has priority.
////////////////////////////////////////////////////////////////////////////

module fetch_bus_ctrl #(
  parameter  int ICACHE_IDX_BITS = fetch_pkg::ICACHE_IDX_BITS,
  localparam int TAG_BITS        = fetch_pkg::ADDR_BITS - fetch_pkg::LINE_OFFSET_BITS
                                   - ICACHE_IDX_BITS
) (
  input  logic                       clock,
  input  logic                       rst_n,

  // Fetch side
  input  fetch_pkg::addr_t           fetch_addr,
  output fetch_pkg::line_t           line_data,
  output logic                       line_valid,

  // Cache arrays
  input  fetch_pkg::line_t           cache_rd_data,
  input  logic                       cache_rd_valid,
  output logic [ICACHE_IDX_BITS-1:0] cache_rd_idx,
  output logic [TAG_BITS-1:0]        cache_rd_tag,
  output logic                       cache_wr_en,
  output logic [ICACHE_IDX_BITS-1:0] cache_wr_idx,
  output logic [TAG_BITS-1:0]        cache_wr_tag,
  output fetch_pkg::line_t           cache_wr_data,

  // Data port and memory bus
  input  fetch_pkg::mem_req_t        data_req,
  input  fetch_pkg::mem_tag_t        mem2proc_response,
  input  fetch_pkg::mem_tag_t        mem2proc_tag,
  input  fetch_pkg::line_t           mem2proc_data,
  output fetch_pkg::mem_req_t        proc2mem_req,
  output fetch_pkg::mem_tag_t        data_response
);

  localparam int OFF = fetch_pkg::LINE_OFFSET_BITS;

  logic                       ctrl_live;      // Out of reset for at least a cycle
  logic                       miss_pending;   // One load in flight
  fetch_pkg::mem_tag_t        pend_tag;
  logic [ICACHE_IDX_BITS-1:0] fill_idx;
  logic [TAG_BITS-1:0]        fill_tag;
  logic                       data_active;
  logic                       miss_start;
  logic                       fill_hit;
  fetch_pkg::mem_tag_t        fetch_response;
  fetch_pkg::mem_req_t        fetch_req;

  ////////////////////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////////////////////

  assign cache_rd_idx = fetch_addr[OFF +: ICACHE_IDX_BITS];
  assign cache_rd_tag = fetch_addr[fetch_pkg::ADDR_BITS-1 -: TAG_BITS];
  assign line_data    = cache_rd_data;
  assign line_valid   = cache_rd_valid;

  ////////////////////////////////////////////////////////////////////////////
  // Miss handling
  ////////////////////////////////////////////////////////////////////////////

  // New miss only once the previous fill has landed
  assign miss_start = ctrl_live && !cache_rd_valid && !miss_pending;
  assign fill_hit   = miss_pending && (mem2proc_tag == pend_tag);

  always_comb
  begin
    fetch_req.command = miss_start ? fetch_pkg::BUS_LOAD : fetch_pkg::BUS_NONE;
    fetch_req.addr    = {fetch_addr[fetch_pkg::ADDR_BITS-1:OFF], {OFF{1'b0}}};
    fetch_req.data    = '0;
  end

  always_ff @(posedge clock)
  begin
    if (!rst_n)
    begin
      ctrl_live    <= 1'b0;
      miss_pending <= 1'b0;
      pend_tag     <= '0;
    end
    else
    begin
      ctrl_live <= 1'b1;
      if (fill_hit)
        miss_pending <= 1'b0;
      else if (miss_start && fetch_response != '0)
      begin
        miss_pending <= 1'b1;
        pend_tag     <= fetch_response;
      end
    end
  end

  // Line address of the accepted miss, kept even if fetch moves on
  always_ff @(posedge clock)
  begin
    if (miss_start && fetch_response != '0)
    begin
      fill_idx <= cache_rd_idx;
      fill_tag <= cache_rd_tag;
    end
  end

  assign cache_wr_en   = fill_hit;
  assign cache_wr_idx  = fill_idx;
  assign cache_wr_tag  = fill_tag;
  assign cache_wr_data = mem2proc_data;

  ////////////////////////////////////////////////////////////////////////////
  // Bus sharing, data port first
  ////////////////////////////////////////////////////////////////////////////

  assign data_active    = (data_req.command != fetch_pkg::BUS_NONE);
  assign proc2mem_req   = data_active ? data_req : fetch_req;
  assign data_response  = data_active ? mem2proc_response : '0;
  assign fetch_response = data_active ? '0 : mem2proc_response;

  // A pending tag is never replaced before its reply returns
  a_single_miss: assert property (@(posedge clock) disable iff (!rst_n)
    (miss_pending && !fill_hit) |=> (miss_pending && $stable(pend_tag)));

  a_data_resp_idle: assert property (@(posedge clock) disable iff (!rst_n)
    (data_req.command == fetch_pkg::BUS_NONE) |-> (data_response == '0));

endmodule

//--- fetch_unit.sv
////////////////////////////////////////////////////////////////////////////
// Fetch stage. Holds the PC, picks the instruction word out of the cache
// line and loads the IF/ID register. Always predicts not taken.
////////////////////////////////////////////////////////////////////////////

module fetch_unit (
  input  logic                  clock,
  input  logic                  rst_n,

  // Mispredict recovery
  input  logic                  redirect,
  input  fetch_pkg::addr_t      redirect_pc,

  // Back-pressure from decode
  input  logic                  decode_stall,

  // Cache side
  input  fetch_pkg::line_t      line_data,
  input  logic                  line_valid,
  output fetch_pkg::addr_t      fetch_addr,

  output fetch_pkg::fetch_pkt_t if_id
);

  fetch_pkg::addr_t pc_q;
  fetch_pkg::addr_t pc_plus4;
  fetch_pkg::inst_t fetch_word;
  logic             advance;

  assign fetch_addr = pc_q;
  assign pc_plus4   = pc_q + 64'd4;

  // Bit 2 picks the upper word of the line
  assign fetch_word = pc_q[2] ? line_data[63:32] : line_data[31:0];
  assign advance    = line_valid && !decode_stall;

  ////////////////////////////////////////////////////////////////////////////
  // Program counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (!rst_n)
      pc_q <= '0;
    else if (redirect)
      pc_q <= redirect_pc;      // Redirect beats stall
    else if (advance)
      pc_q <= pc_plus4;
  end

  ////////////////////////////////////////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (!rst_n || redirect)
    begin
      if_id.npc   <= '0;
      if_id.ir    <= fetch_pkg::NOOP_INST;
      if_id.valid <= 1'b0;
    end
    else if (!decode_stall)
    begin
      // Miss turns into a bubble
      if_id.npc   <= pc_plus4;
      if_id.ir    <= advance ? fetch_word : fetch_pkg::NOOP_INST;
      if_id.valid <= advance;
    end
  end

  // Redirect targets must keep the PC on a word boundary
  a_pc_aligned: assert property (@(posedge clock) disable iff (!rst_n)
    pc_q[1:0] == 2'b00);

endmodule

//--- ooo_fetch_top.sv
////////////////////////////////////////////////////////////////////////////
// Fetch front end top level. Joins the fetch stage, the instruction cache
// arrays and the bus controller that shares memory with the data port.
////////////////////////////////////////////////////////////////////////////

module ooo_fetch_top #(
  parameter  int ICACHE_IDX_BITS = fetch_pkg::ICACHE_IDX_BITS,
  localparam int TAG_BITS        = fetch_pkg::ADDR_BITS - fetch_pkg::LINE_OFFSET_BITS
                                   - ICACHE_IDX_BITS
) (
  input  logic                  clock,
  input  logic                  rst_n,

  // Memory
  input  fetch_pkg::mem_tag_t   mem2proc_response,
  input  fetch_pkg::mem_tag_t   mem2proc_tag,
  input  fetch_pkg::line_t      mem2proc_data,
  output fetch_pkg::mem_req_t   proc2mem_req,

  // Pipeline control
  input  logic                  redirect,
  input  fetch_pkg::addr_t      redirect_pc,
  input  logic                  decode_stall,

  // Data port
  input  fetch_pkg::mem_req_t   data_req,
  output fetch_pkg::mem_tag_t   data_response,

  output fetch_pkg::fetch_pkt_t if_id
);

  fetch_pkg::addr_t           fetch_addr;
  fetch_pkg::line_t           line_data;
  logic                       line_valid;

  // Cache array wiring
  logic [ICACHE_IDX_BITS-1:0] cache_rd_idx;
  logic [TAG_BITS-1:0]        cache_rd_tag;
  fetch_pkg::line_t           cache_rd_data;
  logic                       cache_rd_valid;
  logic                       cache_wr_en;
  logic [ICACHE_IDX_BITS-1:0] cache_wr_idx;
  logic [TAG_BITS-1:0]        cache_wr_tag;
  fetch_pkg::line_t           cache_wr_data;

  fetch_unit fetch_unit_0 (
    .clock        (clock),
    .rst_n        (rst_n),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .decode_stall (decode_stall),
    .line_data    (line_data),
    .line_valid   (line_valid),
    .fetch_addr   (fetch_addr),
    .if_id        (if_id)
  );

  fetch_bus_ctrl #(.ICACHE_IDX_BITS(ICACHE_IDX_BITS)) bus_ctrl_0 (
    .clock             (clock),
    .rst_n             (rst_n),
    .fetch_addr        (fetch_addr),
    .line_data         (line_data),
    .line_valid        (line_valid),
    .cache_rd_data     (cache_rd_data),
    .cache_rd_valid    (cache_rd_valid),
    .cache_rd_idx      (cache_rd_idx),
    .cache_rd_tag      (cache_rd_tag),
    .cache_wr_en       (cache_wr_en),
    .cache_wr_idx      (cache_wr_idx),
    .cache_wr_tag      (cache_wr_tag),
    .cache_wr_data     (cache_wr_data),
    .data_req          (data_req),
    .mem2proc_response (mem2proc_response),
    .mem2proc_tag      (mem2proc_tag),
    .mem2proc_data     (mem2proc_data),
    .proc2mem_req      (proc2mem_req),
    .data_response     (data_response)
  );

  icache_mem #(.ICACHE_IDX_BITS(ICACHE_IDX_BITS)) icache_mem_0 (
    .clock    (clock),
    .rst_n    (rst_n),
    .wr_en    (cache_wr_en),
    .wr_idx   (cache_wr_idx),
    .wr_tag   (cache_wr_tag),
    .wr_data  (cache_wr_data),
    .rd_idx   (cache_rd_idx),
    .rd_tag   (cache_rd_tag),
    .rd_data  (cache_rd_data),
    .rd_valid (cache_rd_valid)
  );

endmodule

//--- tb_mem_model.sv
////////////////////////////////////////////////////////////////////////////
// Testbench memory. Accepts every command under a rotating nonzero tag
// and returns load data a fixed number of cycles after acceptance.
////////////////////////////////////////////////////////////////////////////

module tb_mem_model (
  input  logic                clock,
  input  logic                rst_n,
  input  fetch_pkg::mem_req_t req,
  output fetch_pkg::mem_tag_t response,
  output fetch_pkg::mem_tag_t tag,
  output fetch_pkg::line_t    data
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int LOAD_DELAY = 8;

  fetch_pkg::mem_tag_t next_tag;                // 1 to 15, never zero
  fetch_pkg::mem_tag_t tag_pipe  [LOAD_DELAY];
  fetch_pkg::line_t    data_pipe [LOAD_DELAY];

  // Each word holds its own byte address XOR a fixed pattern
  function automatic fetch_pkg::line_t line_at(input fetch_pkg::addr_t addr);
    logic [31:0] base;
    base = {addr[31:3], 3'b000};
    return {(base + 32'd4) ^ 32'hA5A5_0000, base ^ 32'hA5A5_0000};
  endfunction

  assign response = (rst_n && req.command != fetch_pkg::BUS_NONE) ? next_tag : 4'd0;
  assign tag      = tag_pipe[LOAD_DELAY-1];
  assign data     = data_pipe[LOAD_DELAY-1];

  always_ff @(posedge clock)
  begin
    if (!rst_n)
    begin
      next_tag <= 4'd1;
      for (int i = 0; i < LOAD_DELAY; i++)
        tag_pipe[i] <= 4'd0;
    end
    else
    begin
      // Stores are accepted but never answered
      tag_pipe[0]  <= (req.command == fetch_pkg::BUS_LOAD) ? next_tag : 4'd0;
      data_pipe[0] <= line_at(req.addr);
      for (int i = 1; i < LOAD_DELAY; i++)
      begin
        tag_pipe[i]  <= tag_pipe[i-1];
        data_pipe[i] <= data_pipe[i-1];
      end
      if (req.command != fetch_pkg::BUS_NONE)
        next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
    end
  end

endmodule

//--- tb_ooo_fetch.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the fetch front end. Walks a table of redirects, stalls
// and data-port loads and predicts every IF/ID packet.
////////////////////////////////////////////////////////////////////////////

module tb_ooo_fetch;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD     = 20;
  localparam int RESET_CYCLES   = 16;
  localparam int IDX_BITS       = 7;
  localparam int NUM_ROWS       = 7;
  localparam int CYCLES_PER_PKT = 40;
  localparam fetch_pkg::addr_t    DATA_BASE = 64'h0001_0000;
  localparam fetch_pkg::mem_req_t IDLE_REQ  = '{command: fetch_pkg::BUS_NONE,
                                                addr: '0, data: '0};

  typedef struct packed {
    logic             jump;        // Redirect before collecting
    fetch_pkg::addr_t target;
    int               packets;
    int               stall_max;   // 0 means no stall
    int               data_loads;
    logic             all_hits;    // Whole row must hit in the cache
  } row_t;

  logic                  clock;
  logic                  rst_n;
  logic                  redirect;
  logic                  decode_stall;
  fetch_pkg::addr_t      redirect_pc;
  fetch_pkg::mem_tag_t   mem2proc_response;
  fetch_pkg::mem_tag_t   mem2proc_tag;
  fetch_pkg::line_t      mem2proc_data;
  fetch_pkg::mem_req_t   proc2mem_req;
  fetch_pkg::mem_req_t   data_req;
  fetch_pkg::mem_tag_t   data_response;
  fetch_pkg::fetch_pkt_t if_id;

  row_t                  stim [NUM_ROWS];
  fetch_pkg::addr_t      exp_pc;        // PC of the next packet expected
  fetch_pkg::fetch_pkt_t held_pkt;      // IF/ID as last observed
  int                    got_packets;

  ooo_fetch_top #(.ICACHE_IDX_BITS(IDX_BITS)) dut0 (
    .clock             (clock),
    .rst_n             (rst_n),
    .mem2proc_response (mem2proc_response),
    .mem2proc_tag      (mem2proc_tag),
    .mem2proc_data     (mem2proc_data),
    .proc2mem_req      (proc2mem_req),
    .redirect          (redirect),
    .redirect_pc       (redirect_pc),
    .decode_stall      (decode_stall),
    .data_req          (data_req),
    .data_response     (data_response),
    .if_id             (if_id)
  );

  tb_mem_model mem0 (
    .clock    (clock),
    .rst_n    (rst_n),
    .req      (proc2mem_req),
    .response (mem2proc_response),
    .tag      (mem2proc_tag),
    .data     (mem2proc_data)
  );

  initial
  begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table and predictions
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_table();
    stim[0] = '{1'b0, 64'h0000, 24, 0, 0, 1'b0};  // Straight line from reset
    stim[1] = '{1'b1, 64'h0000, 16, 0, 0, 1'b1};  // Back into cached code
    stim[2] = '{1'b1, 64'h0240, 12, 4, 0, 1'b0};
    stim[3] = '{1'b0, 64'h0000, 10, 0, 3, 1'b0};  // Data port takes the bus
    stim[4] = '{1'b1, 64'h1000, 10, 6, 2, 1'b0};  // Same sets as 0x0 under a new tag
    stim[5] = '{1'b1, 64'h0244, 8, 3, 0, 1'b1};   // Starts on an upper word
    stim[6] = '{1'b1, 64'h0000, 6, 0, 1, 1'b0};   // Refill after eviction
  endtask

  function automatic fetch_pkg::inst_t expected_word(input fetch_pkg::addr_t pc);
    return pc[31:0] ^ 32'hA5A5_0000;
  endfunction

  task automatic check_value(input string name, input logic [129:0] actual,
                             input logic [129:0] expected);
    if (actual !== expected)
    begin
      $display("Fail at %0d ns: %s is %0h, expected %0h", $time, name, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  // IF/ID against the edge that just passed
  task automatic check_packet(input logic stall_used, input logic jump_used,
                              input fetch_pkg::addr_t target_used);
    if (jump_used)
    begin
      check_value("if_id.valid", if_id.valid, 1'b0);
      exp_pc = target_used;
    end
    else if (stall_used)
      check_value("if_id", if_id, held_pkt);
    else if (if_id.valid)
    begin
      check_value("if_id.npc", if_id.npc, exp_pc + 64'd4);
      check_value("if_id.ir", if_id.ir, expected_word(exp_pc));
      exp_pc      = exp_pc + 64'd4;
      got_packets = got_packets + 1;
    end
    held_pkt = if_id;
  endtask

  task automatic check_bus(input logic hits);
    if (data_req.command != fetch_pkg::BUS_NONE)
    begin
      check_value("proc2mem_req", proc2mem_req, data_req);
      check_value("data_response", data_response, mem2proc_response);
    end
    else
    begin
      check_value("data_response", data_response, 4'd0);
      if (hits)
        check_value("proc2mem_req.command", proc2mem_req.command, fetch_pkg::BUS_NONE);
    end
  endtask

  // Drive on the rising edge and check on the falling edge
  task automatic run_cycle(input logic stall_nxt, input logic jump_nxt,
                           input fetch_pkg::addr_t target, input logic load_nxt,
                           input fetch_pkg::addr_t load_addr, input logic hits);
    logic             stall_used;
    logic             jump_used;
    fetch_pkg::addr_t target_used;
    @(posedge clock);
    stall_used   = decode_stall;    // What the DUT sampled on this edge
    jump_used    = redirect;
    target_used  = redirect_pc;
    decode_stall <= stall_nxt;
    redirect     <= jump_nxt;
    redirect_pc  <= target;
    if (load_nxt)
      data_req <= '{command: fetch_pkg::BUS_LOAD, addr: load_addr, data: ~load_addr};
    else
      data_req <= IDLE_REQ;
    @(negedge clock);
    check_packet(stall_used, jump_used, target_used);
    check_bus(hits);
  endtask

  task automatic run_row(input row_t row);
    int               start_count;
    int               stall_left;
    int               loads_left;
    logic             stall_done;
    fetch_pkg::addr_t load_addr;
    if (row.jump)
      run_cycle(1'b0, 1'b1, row.target, 1'b0, '0, 1'b0);
    start_count = got_packets;
    stall_left  = 0;
    loads_left  = row.data_loads;
    stall_done  = 1'b0;
    load_addr   = DATA_BASE;
    while (got_packets - start_count < row.packets || loads_left > 0 || stall_left > 0)
    begin
      // Stall once halfway through the row
      if (!stall_done && row.stall_max > 0 && got_packets - start_count >= row.packets / 2)
      begin
        stall_left = 1 + int'($urandom % row.stall_max);
        stall_done = 1'b1;
      end
      run_cycle(stall_left > 0, 1'b0, '0, loads_left > 0, load_addr, row.all_hits);
      if (stall_left > 0)
        stall_left = stall_left - 1;
      if (loads_left > 0)
      begin
        loads_left = loads_left - 1;
        load_addr  = load_addr + 64'd8;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    void'($urandom(32'h57e0));
    load_table();
    rst_n        <= 1'b0;
    redirect     <= 1'b0;
    redirect_pc  <= '0;
    decode_stall <= 1'b0;
    data_req     <= IDLE_REQ;
    repeat (RESET_CYCLES - 1) @(posedge clock);
    @(negedge clock);
    check_value("proc2mem_req.command", proc2mem_req.command, fetch_pkg::BUS_NONE);
    check_value("if_id.valid", if_id.valid, 1'b0);
    check_value("if_id.ir", if_id.ir, fetch_pkg::NOOP_INST);
    check_value("data_response", data_response, 4'd0);
    held_pkt    = if_id;
    exp_pc      = '0;                   // Fetch starts at address zero
    got_packets = 0;
    @(posedge clock);
    rst_n <= 1'b1;
    for (int r = 0; r < NUM_ROWS; r++)
      run_row(stim[r]);
    $display("TEST PASSED");
    $finish;
  end

  initial
  begin
    int total_packets;
    total_packets = 0;
    @(posedge clock);
    for (int r = 0; r < NUM_ROWS; r++)
      total_packets = total_packets + stim[r].packets;
    repeat (RESET_CYCLES + total_packets * CYCLES_PER_PKT) @(posedge clock);
    $display("Watchdog expired, the run timed out before all rows finished");
    $display("TEST FAILED");
    $fatal(1, "Timeout");
  end

endmodule

//--- ooo_fetch.f
fetch_pkg.sv
icache_mem.sv
fetch_bus_ctrl.sv
fetch_unit.sv
ooo_fetch_top.sv
tb_mem_model.sv
tb_ooo_fetch.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the fetch front end and its testbench with Verilator, then runs it.
# The exit status is nonzero when the build fails or the testbench fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/100ps \
  --top-module tb_ooo_fetch \
  -f ooo_fetch.f \
  -o sim_ooo_fetch \
  && ./obj_dir/sim_ooo_fetch \
  || { echo "Simulation run failed"; exit 1; }
